//--- logic/cpu_pkg.sv
package cpu_pkg;

  // memory timing and geometry
  localparam int MEM_LAT = 3;
  localparam int MEM_WORDS = 256;
  localparam int ADDR_W = $clog2(MEM_WORDS);
  // wide enough to hold MEM_LAT
  localparam int LAT_W = $clog2(MEM_LAT + 1);

  typedef logic [LAT_W-1:0] lat_cnt_t;

  typedef logic [15:0] word_t;

  // codes missing here decode as no-ops
  typedef enum logic [3:0] {
    ADD = 4'h0,
    SUB = 4'h1,
    XOR = 4'h2,
    SLL = 4'h4,
    SRA = 4'h5,
    ROR = 4'h6,
    LW  = 4'h8,
    SW  = 4'h9,
    LLB = 4'ha,
    LHB = 4'hb,
    BR  = 4'hc,
    HLT = 4'hf
  } opcode_e;

  // branch conditions on the flag register
  typedef enum logic [2:0] {NE, EQ, GT, LT, GE, LE, OV, AL} cond_e;

  // register form, rt doubles as imm4 for shifts and memory offsets
  typedef struct packed {
    opcode_e    opcode;
    logic [3:0] rd;
    logic [3:0] rs;
    logic [3:0] rt;
  } rtype_t;

  // byte immediate form (LLB, LHB)
  typedef struct packed {
    opcode_e    opcode;
    logic [3:0] rd;
    logic [7:0] imm8;
  } itype_t;

  // branch form with a word offset
  typedef struct packed {
    opcode_e    opcode;
    cond_e      cond;
    logic [8:0] off9;
  } btype_t;

  // three views of the same 16 bits
  typedef union packed {
    rtype_t r;
    itype_t i;
    btype_t b;
  } instr_t;

  typedef struct packed {
    logic z;
    logic v;
    logic n;
  } flags_t;

  // memory fill port, used while the core is stopped
  typedef struct packed {
    logic              en;
    logic              dmem;
    logic [ADDR_W-1:0] addr;
    word_t             data;
  } load_t;

  // one entry per committed instruction
  typedef struct packed {
    logic       valid;
    word_t      pc;
    logic       wr;
    logic [3:0] rd;
    word_t      data;
  } retire_t;

  // controller states
  typedef enum logic [2:0] {IDLE, FETCH, DECODE, EXEC, MEM, WB, HALT} state_e;

endpackage

//--- logic/cpu_ctrl.sv
module cpu_ctrl (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  logic             done,
  input  cpu_pkg::opcode_e opcode,
  output logic             timer_start,
  output logic             ir_load,
  output logic             dmem_wr,
  output logic             reg_wr,
  output logic             flag_wr,
  output logic             pc_load,
  output logic             retire_valid,
  output logic             hlt,
  output logic             use_dmem
);

  cpu_pkg::state_e state;
  cpu_pkg::state_e state_nx;

  // decoded instruction classes
  logic writes_reg;
  logic writes_flags;
  logic is_mem;
  logic is_hlt;

  always_comb begin
    writes_reg   = 1'b0;
    writes_flags = 1'b0;
    case (opcode)
      cpu_pkg::ADD, cpu_pkg::SUB, cpu_pkg::XOR,
      cpu_pkg::SLL, cpu_pkg::SRA, cpu_pkg::ROR: begin
        writes_reg   = 1'b1;
        writes_flags = 1'b1;
      end
      // loads write a register but leave the flags
      cpu_pkg::LW, cpu_pkg::LLB, cpu_pkg::LHB: writes_reg = 1'b1;
      default: ;
    endcase
  end

  assign is_mem = (opcode == cpu_pkg::LW) || (opcode == cpu_pkg::SW);
  assign is_hlt = (opcode == cpu_pkg::HLT);

  always_comb begin
    state_nx = state;
    case (state)
      cpu_pkg::IDLE:   if (run) state_nx = cpu_pkg::FETCH;
      cpu_pkg::FETCH:  if (done) state_nx = cpu_pkg::DECODE;
      cpu_pkg::DECODE: state_nx = cpu_pkg::EXEC;
      cpu_pkg::EXEC:   state_nx = is_mem ? cpu_pkg::MEM : cpu_pkg::WB;
      cpu_pkg::MEM:    if (done) state_nx = cpu_pkg::WB;
      cpu_pkg::WB: begin
        // a dropped run lets the current instruction finish first
        if (is_hlt) state_nx = cpu_pkg::HALT;
        else if (run) state_nx = cpu_pkg::FETCH;
        else state_nx = cpu_pkg::IDLE;
      end
      // only reset leaves HALT
      default: state_nx = cpu_pkg::HALT;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= cpu_pkg::IDLE;
    end else begin
      state <= state_nx;
    end
  end

  // fetch wait is launched on the way into FETCH so the fetch costs MEM_LAT cycles
  // MEM holds start high, the timer ignores it once busy
  assign timer_start = ((state_nx == cpu_pkg::FETCH) && (state != cpu_pkg::FETCH))
                       || (state == cpu_pkg::MEM);

  assign ir_load = (state == cpu_pkg::FETCH) && done;
  // single store write at the end of the access
  assign dmem_wr = (state == cpu_pkg::MEM) && done && (opcode == cpu_pkg::SW);
  assign flag_wr = (state == cpu_pkg::EXEC) && writes_flags;
  assign reg_wr = (state == cpu_pkg::WB) && writes_reg;
  // pc stays on the HLT word
  assign pc_load = (state == cpu_pkg::WB) && !is_hlt;
  assign retire_valid = (state == cpu_pkg::WB);
  assign hlt = (state == cpu_pkg::HALT);
  // write-back source select
  assign use_dmem = (opcode == cpu_pkg::LW);

endmodule

//--- logic/mem_wait_timer.sv
module mem_wait_timer (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic done
);

  // cycles left in the current access, zero when idle
  cpu_pkg::lat_cnt_t count;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count <= '0;
    end else if (count != '0) begin
      // busy, a start here is dropped
      count <= count - 1'b1;
    end else if (start) begin
      count <= cpu_pkg::lat_cnt_t'(cpu_pkg::MEM_LAT);
    end
  end

  // last cycle of the wait, MEM_LAT cycles after the start
  // count hits zero on the following edge
  assign done = (count == cpu_pkg::lat_cnt_t'(1));

endmodule

//--- logic/word_mem.sv
module word_mem #(
  parameter type payload_t = cpu_pkg::word_t
) (
  input  logic                      clk,
  input  logic                      wr,
  input  logic [cpu_pkg::ADDR_W-1:0] addr,
  input  payload_t                  wdata,
  output payload_t                  rdata
);

  // storage array, word addressed
  payload_t mem [cpu_pkg::MEM_WORDS];

  always_ff @(posedge clk) begin
    if (wr) begin
      mem[addr] <= wdata;
    end
    // registered read, old contents on a same-cycle write
    rdata <= mem[addr];
  end

endmodule

//--- logic/reg_file.sv
module reg_file (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           wr,
  input  logic [3:0]     rs,
  input  logic [3:0]     rt,
  input  logic [3:0]     rd,
  input  cpu_pkg::word_t wdata,
  input  logic           flag_wr,
  input  cpu_pkg::flags_t flags_in,
  output cpu_pkg::word_t rs_data,
  output cpu_pkg::word_t rt_data,
  output cpu_pkg::flags_t flags
);

  // r0 is cleared by reset and never written
  cpu_pkg::word_t regs [16];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (wr && (rd != 4'd0)) begin
      regs[rd] <= wdata;
    end
  end

  // combinational read ports
  // no bypass, writes land at the end of WB
  assign rs_data = regs[rs];
  assign rt_data = regs[rt];

  // flags_in arrives already merged with the old value
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (flag_wr) begin
      flags <= flags_in;
    end
  end

endmodule

//--- logic/alu.sv
module alu (
  input  cpu_pkg::instr_t ir,
  input  cpu_pkg::word_t  pc,
  input  cpu_pkg::word_t  rs_data,
  input  cpu_pkg::word_t  rt_data,
  input  cpu_pkg::flags_t flags,
  output cpu_pkg::word_t  result,
  output cpu_pkg::flags_t flags_out,
  output cpu_pkg::flags_t flag_mask,
  output cpu_pkg::word_t  next_pc
);

  cpu_pkg::word_t pc_inc;
  cpu_pkg::word_t br_off;
  cpu_pkg::word_t mem_off;
  logic [31:0]    rot;
  logic           taken;

  assign pc_inc = pc + 16'd2;
  // word offsets, sign extended then scaled to bytes
  assign br_off = {{6{ir.b.off9[8]}}, ir.b.off9, 1'b0};
  assign mem_off = {{11{ir.r.rt[3]}}, ir.r.rt, 1'b0};
  // doubled operand makes rotate a plain right shift
  assign rot = {rs_data, rs_data} >> ir.r.rt;

  always_comb begin
    result = '0;
    flags_out.v = 1'b0;
    flag_mask = '0;
    case (ir.r.opcode)
      cpu_pkg::ADD: begin
        result = rs_data + rt_data;
        // same input signs, different result sign
        flags_out.v = (rs_data[15] == rt_data[15]) && (result[15] != rs_data[15]);
        flag_mask = '1;
      end
      cpu_pkg::SUB: begin
        result = rs_data - rt_data;
        flags_out.v = (rs_data[15] != rt_data[15]) && (result[15] != rs_data[15]);
        flag_mask = '1;
      end
      cpu_pkg::XOR: begin
        result = rs_data ^ rt_data;
        flag_mask.z = 1'b1;
      end
      cpu_pkg::SLL: begin
        result = rs_data << ir.r.rt;
        flag_mask.z = 1'b1;
      end
      cpu_pkg::SRA: begin
        result = $signed(rs_data) >>> ir.r.rt;
        flag_mask.z = 1'b1;
      end
      cpu_pkg::ROR: begin
        result = rot[15:0];
        flag_mask.z = 1'b1;
      end
      // byte address for the data memory
      cpu_pkg::LW, cpu_pkg::SW: result = rs_data + mem_off;
      // rs_data holds rd here
      cpu_pkg::LLB: result = {rs_data[15:8], ir.i.imm8};
      cpu_pkg::LHB: result = {ir.i.imm8, rs_data[7:0]};
      default: ;
    endcase
    flags_out.z = (result == '0);
    flags_out.n = result[15];
  end

  always_comb begin
    case (ir.b.cond)
      cpu_pkg::NE: taken = !flags.z;
      cpu_pkg::EQ: taken = flags.z;
      cpu_pkg::GT: taken = !flags.z && !flags.n;
      cpu_pkg::LT: taken = flags.n;
      cpu_pkg::GE: taken = flags.z || !flags.n;
      cpu_pkg::LE: taken = flags.n || flags.z;
      cpu_pkg::OV: taken = flags.v;
      default:     taken = 1'b1;
    endcase
  end

  // relative to the following instruction
  assign next_pc = ((ir.b.opcode == cpu_pkg::BR) && taken) ? pc_inc + br_off : pc_inc;

endmodule

//--- logic/cpu.sv
module cpu (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  cpu_pkg::load_t   load,
  output logic             hlt,
  output cpu_pkg::word_t   pc,
  output cpu_pkg::retire_t retire
);

  logic timer_start, done, ir_load, dmem_wr, reg_wr, flag_wr, pc_load;
  logic retire_valid, use_dmem, decode_q, load_imem, load_dmem;
  logic [3:0] rs_sel, rt_sel;
  logic [cpu_pkg::ADDR_W-1:0] imem_addr, dmem_addr;
  cpu_pkg::instr_t ir, imem_rdata;
  cpu_pkg::word_t  rs_data, rt_data, alu_res, res_q, next_pc, dmem_rdata, dmem_wdata, wb_data;
  cpu_pkg::flags_t flags, alu_flags, flag_mask, flags_in;

  // the load port owns a memory only while the core is stopped
  assign load_imem = load.en && !load.dmem && !run;
  assign load_dmem = load.en && load.dmem && !run;
  // word index drops the byte bit
  assign imem_addr = load_imem ? load.addr : pc[cpu_pkg::ADDR_W:1];
  assign dmem_addr = load_dmem ? load.addr : res_q[cpu_pkg::ADDR_W:1];
  assign dmem_wdata = load_dmem ? load.data : rt_data;

  // byte loads modify rd, stores read their data from rd
  assign rs_sel = ((ir.r.opcode == cpu_pkg::LLB) || (ir.r.opcode == cpu_pkg::LHB)) ?
                  ir.r.rd : ir.r.rs;
  assign rt_sel = (ir.r.opcode == cpu_pkg::SW) ? ir.r.rd : ir.r.rt;

  // only the flags the opcode owns change
  assign flags_in = (alu_flags & flag_mask) | (flags & ~flag_mask);
  // dmem address holds through WB so the read word is still there
  assign wb_data = use_dmem ? dmem_rdata : res_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= '0;
      ir <= '0;
      decode_q <= 1'b0;
    end else begin
      if (pc_load) pc <= next_pc;
      if (ir_load) ir <= imem_rdata;
      // high through the DECODE cycle
      decode_q <= ir_load;
    end
  end

  // result register, operands are steady from DECODE until WB
  always_ff @(posedge clk) begin
    if (decode_q) res_q <= alu_res;
  end

  always_comb begin
    retire.valid = retire_valid;
    retire.pc = pc;
    retire.wr = reg_wr;
    retire.rd = ir.r.rd;
    retire.data = wb_data;
  end

  cpu_ctrl ctrl0 (.clk(clk), .rst_n(rst_n), .run(run), .done(done), .opcode(ir.r.opcode),
    .timer_start(timer_start), .ir_load(ir_load), .dmem_wr(dmem_wr), .reg_wr(reg_wr),
    .flag_wr(flag_wr), .pc_load(pc_load), .retire_valid(retire_valid), .hlt(hlt),
    .use_dmem(use_dmem));

  mem_wait_timer timer0 (.clk(clk), .rst_n(rst_n), .start(timer_start), .done(done));

  word_mem #(.payload_t(cpu_pkg::instr_t)) imem0 (.clk(clk), .wr(load_imem),
    .addr(imem_addr), .wdata(cpu_pkg::instr_t'(load.data)), .rdata(imem_rdata));

  word_mem #(.payload_t(cpu_pkg::word_t)) dmem0 (.clk(clk), .wr(load_dmem || dmem_wr),
    .addr(dmem_addr), .wdata(dmem_wdata), .rdata(dmem_rdata));

  reg_file rf0 (.clk(clk), .rst_n(rst_n), .wr(reg_wr), .rs(rs_sel), .rt(rt_sel),
    .rd(ir.r.rd), .wdata(wb_data), .flag_wr(flag_wr), .flags_in(flags_in),
    .rs_data(rs_data), .rt_data(rt_data), .flags(flags));

  alu alu0 (.ir(ir), .pc(pc), .rs_data(rs_data), .rt_data(rt_data), .flags(flags),
    .result(alu_res), .flags_out(alu_flags), .flag_mask(flag_mask), .next_pc(next_pc));

endmodule

//--- verif/cpu_assert.sv
module cpu_assert (
  input logic            clk,
  input logic            rst_n,
  input logic            hlt,
  input logic            retire_valid,
  input logic            dmem_wr,
  input cpu_pkg::state_e state
);

  timeunit 1ns;
  timeprecision 100ps;

  // failure count, read by the testbench top
  int fails = 0;

  // halt is sticky until reset
  hlt_held: assert property (@(posedge clk) disable iff (!rst_n) hlt |=> hlt)
    else begin
      fails++;
      $error("hlt fell without a reset");
    end

  // one retire per instruction, at least 4 cycles apart
  retire_single: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |=> !retire_valid)
    else begin
      fails++;
      $error("retire strobe high on two consecutive cycles");
    end

  // stores land only at the end of a data access
  store_in_mem: assert property (@(posedge clk) disable iff (!rst_n)
    dmem_wr |-> (state == cpu_pkg::MEM))
    else begin
      fails++;
      $error("data memory write outside the MEM state");
    end

endmodule

//--- verif/cpu_check.sv
module cpu_check (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             run,
  input  cpu_pkg::load_t   load,
  input  logic             hlt,
  input  cpu_pkg::word_t   pc,
  input  cpu_pkg::retire_t retire,
  output int               errors,
  output int               retired
);

  timeunit 1ns;
  timeprecision 100ps;

  // architectural copy of the machine
  logic [15:0] m_imem [256];
  logic [15:0] m_dmem [256];
  logic [15:0] m_reg [16];
  logic [15:0] m_pc;
  logic m_z, m_v, m_n;
  logic m_halted;
  logic hlt_seen;

  initial begin
    errors = 0;
    retired = 0;
  end

  task automatic compare(input string name, input logic [15:0] got, input logic [15:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERR %s: got %h expected %h", name, got, exp);
    end
  endtask

  function automatic logic cond_holds(input logic [2:0] c);
    case (c)
      3'd0: return !m_z;
      3'd1: return m_z;
      3'd2: return !m_z && !m_n;
      3'd3: return m_n;
      3'd4: return m_z || !m_n;
      3'd5: return m_n || m_z;
      3'd6: return m_v;
      default: return 1'b1;
    endcase
  endfunction

  // execute one instruction of the model and compare it with the retire entry
  task automatic retire_step();
    logic [15:0] ins, a, b, res, addr, npc;
    logic [3:0] op, rd, rs, rt;
    logic wr, arith, zonly;
    int wide;
    ins = m_imem[m_pc[8:1]];
    op = ins[15:12];
    rd = ins[11:8];
    rs = ins[7:4];
    rt = ins[3:0];
    a = m_reg[rs];
    b = m_reg[rt];
    addr = a + {{11{rt[3]}}, rt, 1'b0};
    npc = m_pc + 16'd2;
    res = '0;
    wr = 1'b0;
    arith = 1'b0;
    zonly = 1'b0;
    case (op)
      4'h0: begin
        res = a + b;
        arith = 1'b1;
        // overflow when the exact signed sum leaves the 16-bit range
        wide = $signed(a) + $signed(b);
        m_v = (wide > 32767) || (wide < -32768);
      end
      4'h1: begin
        res = a - b;
        arith = 1'b1;
        wide = $signed(a) - $signed(b);
        m_v = (wide > 32767) || (wide < -32768);
      end
      4'h2: begin
        res = a ^ b;
        zonly = 1'b1;
      end
      4'h4: begin
        res = a << rt;
        zonly = 1'b1;
      end
      4'h5: begin
        // logical shift with the sign copied into the vacated top bits
        res = (a >> rt) | ({16{a[15]}} << (5'd16 - {1'b0, rt}));
        zonly = 1'b1;
      end
      4'h6: begin
        res = (a >> rt) | (a << (5'd16 - {1'b0, rt}));
        zonly = 1'b1;
      end
      4'h8: begin
        res = m_dmem[addr[8:1]];
        wr = 1'b1;
      end
      // store data comes from rd
      4'h9: m_dmem[addr[8:1]] = m_reg[rd];
      4'ha: begin
        res = {m_reg[rd][15:8], ins[7:0]};
        wr = 1'b1;
      end
      4'hb: begin
        res = {ins[7:0], m_reg[rd][7:0]};
        wr = 1'b1;
      end
      4'hc: if (cond_holds(ins[11:9])) npc = npc + {{6{ins[8]}}, ins[8:0], 1'b0};
      4'hf: begin
        m_halted = 1'b1;
        npc = m_pc;
      end
      default: ;
    endcase
    if (arith || zonly) begin
      wr = 1'b1;
      m_z = (res == 16'd0);
    end
    // N only from add and sub
    if (arith) m_n = res[15];
    compare("retire.pc", retire.pc, m_pc);
    compare("retire.wr", 16'(retire.wr), 16'(wr));
    compare("retire.rd", 16'(retire.rd), 16'(rd));
    if (wr) compare("retire.data", retire.data, res);
    if (wr && rd != 4'd0) m_reg[rd] = res;
    m_pc = npc;
    retired++;
  endtask

  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        m_reg[i] = '0;
      end
      {m_z, m_v, m_n} = '0;
      m_pc = '0;
      m_halted = 1'b0;
      hlt_seen = 1'b0;
    end else begin
      // mirror the load port while the core is stopped
      if (load.en && !run) begin
        if (load.dmem) m_dmem[load.addr] = load.data;
        else m_imem[load.addr] = load.data;
      end
      if (retire.valid) begin
        if (!run) begin
          errors++;
          $display("instruction retired while the core was stopped");
        end else if (m_halted) begin
          errors++;
          $display("instruction retired after the core halted");
        end else begin
          retire_step();
        end
      end
      if (hlt) begin
        if (!m_halted) begin
          if (!hlt_seen) begin
            errors++;
            $display("core halted before the model reached HLT");
          end
        end else begin
          // pc stays on the HLT word for as long as the core is halted
          compare("pc", pc, m_pc);
        end
        hlt_seen = 1'b1;
      end
    end
  end

endmodule

//--- verif/cpu_tb.sv
module cpu_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int NUM_TESTS = 15;
  localparam int MAX_LEN = 40;
  // worst case run plus loading and reset per test
  localparam int LIMIT = NUM_TESTS * (41 * (4 + 2 * cpu_pkg::MEM_LAT) + MAX_LEN
                         + cpu_pkg::MEM_WORDS + 20) + 100;

  logic clk = 1'b0;
  logic rst_n;
  logic run;
  cpu_pkg::load_t load;
  logic hlt;
  cpu_pkg::word_t pc;
  cpu_pkg::retire_t retire;
  int errors;
  int retired;
  int cycles = 0;
  logic [31:0] seed;
  logic [15:0] prog [MAX_LEN];

  always #50 clk = ~clk;

  cpu dut0 (.clk(clk), .rst_n(rst_n), .run(run), .load(load), .hlt(hlt), .pc(pc),
    .retire(retire));

  cpu_check chk0 (.clk(clk), .rst_n(rst_n), .run(run), .load(load), .hlt(hlt), .pc(pc),
    .retire(retire), .errors(errors), .retired(retired));

  bind cpu_ctrl cpu_assert assert0 (.clk(clk), .rst_n(rst_n), .hlt(hlt),
    .retire_valid(retire_valid), .dmem_wr(dmem_wr), .state(state));

  // global watchdog
  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("timeout: core never halted");
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic logic [31:0] rand_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // upper bits only since the low ones of an LCG cycle quickly
  function automatic int rand_below(input int n);
    return int'((rand_next() >> 16) % 32'(n));
  endfunction

  // eight opcode slots per test kind with one nibble each
  function automatic logic [31:0] op_table(input int kind);
    case (kind)
      0: return 32'hab01_2456;
      1: return 32'habab_ab02;
      2: return 32'h9988_ab09;
      3: return 32'hcccb_0125;
      default: return 32'h0146_89bc;
    endcase
  endfunction

  function automatic logic [15:0] make_instr(input int kind, input int i, input int len);
    logic [31:0] tbl;
    logic [3:0] op;
    logic [15:0] w;
    int tgt;
    tbl = op_table(kind);
    op = tbl[4 * rand_below(8) +: 4];
    w = 16'(rand_next() >> 16);
    if (op == 4'hc) begin
      // forward only and at most onto the HLT
      tgt = i + 1 + rand_below(len - 1 - i);
      return {4'hc, 3'(rand_below(8)), 9'(tgt - i - 1)};
    end
    // small base registers so memory addresses collide
    if (op == 4'h8 || op == 4'h9) w[7:6] = 2'b00;
    return {op, w[11:0]};
  endfunction

  task automatic write_word(input logic dmem, input int addr, input logic [15:0] data);
    load.en = 1'b1;
    load.dmem = dmem;
    load.addr = 8'(addr);
    load.data = data;
    @(negedge clk);
  endtask

  task automatic run_test(input int t);
    int kind, len, err0, ret0;
    kind = t % 5;
    len = 8 + rand_below(MAX_LEN - 7);
    err0 = errors;
    ret0 = retired;
    for (int i = 0; i < len - 1; i++) begin
      prog[i] = make_instr(kind, i, len);
    end
    prog[len-1] = 16'hf000;
    for (int i = 0; i < len; i++) begin
      write_word(1'b0, i, prog[i]);
    end
    for (int i = 0; i < cpu_pkg::MEM_WORDS; i++) begin
      write_word(1'b1, i, 16'(rand_next() >> 16));
    end
    load.en = 1'b0;
    run = 1'b1;
    while (!hlt) @(negedge clk);
    // a few idle cycles to catch retires after halt
    repeat (4) @(negedge clk);
    run = 1'b0;
    $display("test %0d kind %0d: %0d retired, %0d errors", t, kind, retired - ret0,
      errors - err0);
    rst_n = 1'b0;
    @(negedge clk);
    rst_n = 1'b1;
  endtask

  initial begin
    seed = 32'h728c_311c;
    rst_n = 1'b0;
    run = 1'b0;
    load = '0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    for (int t = 0; t < NUM_TESTS; t++) begin
      run_test(t);
    end
    $display("%0d tests, %0d retired, %0d errors, %0d assertion failures", NUM_TESTS,
      retired, errors, dut0.ctrl0.assert0.fails);
    if (errors == 0 && dut0.ctrl0.assert0.fails == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- compile.f
logic/cpu_pkg.sv
logic/cpu_ctrl.sv
logic/mem_wait_timer.sv
logic/word_mem.sv
logic/reg_file.sv
logic/alu.sv
logic/cpu.sv
verif/cpu_assert.sv
verif/cpu_check.sv
verif/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_tb
OBJ_DIR   ?= obj_dir
FILELIST  ?= compile.f
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
